/* include/serdes_macros.svh */
`ifndef SERDES_MACROS_SVH
`define SERDES_MACROS_SVH

// transmit side
// one tx word per lane, shifted out msb first
`define SERDES_TX_WIDTH 8 // bits per transmitted word, also the tx strobe divide

// receive side
// single lane, gathered msb = oldest sample
`define SERDES_RX_WIDTH 4 // bits per received word, also the rx strobe divide

// lock indication
// stands in for pll lock plus strobe alignment
// counted in tx strobes after reset release
`define SERDES_LOCK_STROBES 4 // tx strobes seen before locked goes high

// first word load happens on strobe number SERDES_LOCK_STROBES+1
// both lanes idle high until then
// rx runs freely and does not wait for lock
// all three values must stay at 2 or more
// the strobe counters need at least one idle clock

`endif

/* src/serdes_pkg.sv */
`default_nettype none

`include "serdes_macros.svh"

package serdes_pkg;

	// one parallel word for a single tx lane
	typedef logic [`SERDES_TX_WIDTH-1:0] tx_word_t;

	// both tx words, loaded together on one strobe
	typedef struct packed {
		tx_word_t word1; // goes out on d1
		tx_word_t word2; // goes out on d2
	} tx_pair_t;

	// the two serial lines, one bit each
	typedef struct packed {
		logic d1; // lane 1 line, idles high
		logic d2; // lane 2 line, idles high
	} serial_pair_t;

	// one gathered rx word, oldest bit in the msb
	typedef logic [`SERDES_RX_WIDTH-1:0] rx_word_t;

	// lock fsm states
	typedef enum logic [1:0] {
		lock_wait,  // no strobe seen yet
		lock_count, // counting strobes toward lock
		lock_done   // locked, held until reset
	} lock_state_t;

endpackage

`default_nettype wire

/* src/strobe_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module strobe_gen #(
	parameter int DIVIDE = 8 // clocks per strobe period
) (
	input wire clock,
	input wire rst_n,
	output logic strobe // one clock high per DIVIDE clocks
);

	localparam int CW = (DIVIDE > 2) ? $clog2(DIVIDE) : 1; // counter width
	localparam logic [CW-1:0] LAST = CW'(DIVIDE - 1); // terminal count

	logic [CW-1:0] count; // position inside the word period

	// modulo-DIVIDE counter, starts at zero after reset release
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			count <= '0;
		end else if (count == LAST) begin
			count <= '0; // wrap, strobe was high this clock
		end else begin
			count <= count + 1'b1;
		end
	end

	// high during the DIVIDE-th clock of each period
	// stands in for the divided word clock of the hard serdes
	assign strobe = (count == LAST);

	// no second strobe may land inside the same word period
	// checked back over each of the DIVIDE-1 previous edges
	genvar k;
	generate
		for (k = 1; k < DIVIDE; k++) begin : g_gap
			a_strobe_gap: assert property (
				@(posedge clock) disable iff (!rst_n)
				strobe |-> !$past(strobe, k)
			) else $error("strobe_gen: strobe %0d clocks after previous one", k);
		end
	endgenerate

	// the period must actually recur, otherwise words stall
	a_strobe_recur: assert property (
		@(posedge clock) disable iff (!rst_n)
		strobe |-> ##DIVIDE strobe
	) else $error("strobe_gen: strobe missing after %0d clocks", DIVIDE);

endmodule

`default_nettype wire

/* src/lock_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "serdes_macros.svh"

module lock_monitor (
	input wire clock,
	input wire rst_n,
	input wire strobe, // tx word strobe
	output logic locked // level, stays high until reset
);

	localparam int CW = $clog2(`SERDES_LOCK_STROBES + 1); // strobe counter width
	localparam logic [CW-1:0] LAST = CW'(`SERDES_LOCK_STROBES - 1); // count before lock

	serdes_pkg::lock_state_t state; // current fsm state
	logic [CW-1:0] count; // strobes seen so far

	// models pll lock and strobe alignment settling over a few word periods
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= serdes_pkg::lock_wait;
			count <= '0;
		end else begin
			unique case (state)
				serdes_pkg::lock_wait: begin
					if (strobe) begin
						state <= serdes_pkg::lock_count;
						count <= count + 1'b1; // first strobe already counts toward lock
					end
				end
				serdes_pkg::lock_count: begin
					if (strobe) begin
						if (count == LAST) begin
							state <= serdes_pkg::lock_done; // this edge samples the last strobe
						end else begin
							count <= count + 1'b1;
						end
					end
				end
				serdes_pkg::lock_done: begin
					state <= serdes_pkg::lock_done; // sticky until reset
				end
				default: begin
					state <= serdes_pkg::lock_wait; // unused encoding, restart
					count <= '0;
				end
			endcase
		end
	end

	// high from the edge that samples the last counted strobe
	assign locked = (state == serdes_pkg::lock_done);

	// lock is a one-way flag once reset is gone
	a_lock_sticky: assert property (
		@(posedge clock) disable iff (!rst_n)
		locked |=> locked
	) else $error("lock_monitor: locked fell outside reset");

endmodule

`default_nettype wire

/* src/oserdes_lane.sv */
`timescale 1ns/1ps
`default_nettype none

`include "serdes_macros.svh"

module oserdes_lane (
	input wire clock,
	input wire rst_n,
	input wire strobe, // word strobe, once per SERDES_TX_WIDTH clocks
	input wire locked, // loads only once lock is up
	input wire serdes_pkg::tx_word_t word, // parallel word, sampled on strobe
	output logic line // serial output, msb first
);

	localparam int W = `SERDES_TX_WIDTH; // shift register length

	serdes_pkg::tx_word_t shreg; // parallel-to-serial shift register
	logic load; // strobe qualified by lock

	assign load = strobe & locked;

	// load on a locked strobe, else shift left
	// ones fill in from the bottom like the cascade fill bits,
	// so an unloaded lane drains to all ones and the line idles high
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			shreg <= '1; // idle pattern
		end else if (load) begin
			shreg <= word; // msb goes out on the next edge
		end else begin
			shreg <= {shreg[W-2:0], 1'b1}; // next bit up, fill with one
		end
	end

	// output flop after the shift register
	// the edge after a load shows bit W-1, the W-th edge shows bit 0,
	// which is also the next strobe, so words follow with no gap
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			line <= 1'b1; // line idles high through reset
		end else begin
			line <= shreg[W-1];
		end
	end

	// every loaded word must reach the line intact, msb first
	a_msb_first: assert property (
		@(posedge clock) disable iff (!rst_n)
		load |-> ##2 (line == $past(word[W-1], 2))
	) else $error("oserdes_lane: msb not on line after load");

	// the last bit leaves on the edge of the following strobe
	a_lsb_last: assert property (
		@(posedge clock) disable iff (!rst_n)
		load |-> ##(W+1) (line == $past(word[0], W+1))
	) else $error("oserdes_lane: lsb not on line %0d clocks after load", W);

endmodule

`default_nettype wire

/* src/iserdes_lane.sv */
`timescale 1ns/1ps
`default_nettype none

`include "serdes_macros.svh"

module iserdes_lane (
	input wire clock,
	input wire rst_n,
	input wire strobe, // rx word strobe, once per SERDES_RX_WIDTH clocks
	input wire data_in, // serial input, sampled every edge
	output serdes_pkg::rx_word_t word, // gathered word, oldest bit in msb
	output logic valid // one clock pulse per new word
);

	localparam int W = `SERDES_RX_WIDTH; // bits per gathered word

	logic [W-2:0] samples; // previous W-1 samples, newest in lsb

	// sampling shift register, runs every clock
	always_ff @(posedge clock) begin
		samples <= (W-1)'({samples, data_in}); // oldest sample drops out the top
	end

	// capture on the strobe edge, including the bit sampled on that edge
	always_ff @(posedge clock) begin
		if (strobe) begin
			word <= {samples, data_in}; // oldest of the four ends up in the msb
		end
	end

	// word pulse, high for the clock after the capture edge
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			valid <= 1'b0;
		end else begin
			valid <= strobe;
		end
	end

	// the rx strobe period keeps words apart
	// back-to-back valids would mean overlapping bits
	a_valid_single: assert property (
		@(posedge clock) disable iff (!rst_n)
		valid |=> !valid
	) else $error("iserdes_lane: valid high on two consecutive clocks");

endmodule

`default_nettype wire

/* src/serdes_io.sv */
`timescale 1ns/1ps
`default_nettype none

`include "serdes_macros.svh"

module serdes_io (
	input wire clock, // fast bit clock, everything runs here
	input wire rst_n,
	input wire serdes_pkg::tx_pair_t tx_words, // both tx words, sampled on tx_strobe
	input wire data_in, // serial rx input
	output serdes_pkg::serial_pair_t tx_lines, // d1 and d2 serial outputs
	output logic tx_strobe, // word strobe, once per SERDES_TX_WIDTH clocks
	output logic locked, // lock level
	output serdes_pkg::rx_word_t rx_word, // gathered rx word
	output logic rx_valid // pulse per rx word
);

	logic rx_strobe; // rx word strobe, internal to the receive path
	logic d1_line; // lane 1 serial out
	logic d2_line; // lane 2 serial out

	// transmit word strobe, replaces the divided fabric clock
	strobe_gen #(
		.DIVIDE(`SERDES_TX_WIDTH)
	) tx_strobe_gen (
		.clock (clock),
		.rst_n (rst_n),
		.strobe(tx_strobe)
	);

	// lock from counted tx strobes
	lock_monitor lock_mon (
		.clock (clock),
		.rst_n (rst_n),
		.strobe(tx_strobe),
		.locked(locked)
	);

	// lane 1, word1 out on d1
	oserdes_lane lane1 (
		.clock (clock),
		.rst_n (rst_n),
		.strobe(tx_strobe),
		.locked(locked),
		.word  (tx_words.word1),
		.line  (d1_line)
	);

	// lane 2, same strobe so both words leave together
	oserdes_lane lane2 (
		.clock (clock),
		.rst_n (rst_n),
		.strobe(tx_strobe),
		.locked(locked),
		.word  (tx_words.word2),
		.line  (d2_line)
	);

	assign tx_lines = '{d1: d1_line, d2: d2_line};

	// receive side has its own strobe and ignores lock
	strobe_gen #(
		.DIVIDE(`SERDES_RX_WIDTH)
	) rx_strobe_gen (
		.clock (clock),
		.rst_n (rst_n),
		.strobe(rx_strobe)
	);

	// 1:4 deserializer
	iserdes_lane rx_lane (
		.clock  (clock),
		.rst_n  (rst_n),
		.strobe (rx_strobe),
		.data_in(data_in),
		.word   (rx_word),
		.valid  (rx_valid)
	);

endmodule

`default_nettype wire

/* test/serdes_io_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "serdes_macros.svh"

module serdes_io_tb;

	localparam int CLK_PERIOD = 100; // ns
	localparam int TX_W = `SERDES_TX_WIDTH; // tx strobe divide and word width
	localparam int RX_W = `SERDES_RX_WIDTH; // rx strobe divide and word width
	localparam int LOCK_N = `SERDES_LOCK_STROBES;
	localparam logic [31:0] SEED = 32'haf2bacb8;
	localparam int RESET_CYCLES = 5;
	localparam int SETTLE_CYCLES = 2; // right after release
	localparam int LOCK_CYCLES = (LOCK_N + 2) * TX_W; // runs past lock and the first load
	localparam int SERIAL_CYCLES = 800;
	localparam int DESERIAL_CYCLES = 400;
	localparam int LOOP_CYCLES = 400;
	localparam int TOTAL_CYCLES = RESET_CYCLES + SETTLE_CYCLES + LOCK_CYCLES
		+ SERIAL_CYCLES + DESERIAL_CYCLES + LOOP_CYCLES;
	localparam int WATCHDOG_NS = (TOTAL_CYCLES + 100) * CLK_PERIOD; // margin of 100 clocks

	logic clock = 1'b0;
	logic rst_n;
	serdes_pkg::tx_pair_t tx_words;
	logic data_in;
	serdes_pkg::serial_pair_t tx_lines;
	logic tx_strobe;
	logic locked;
	serdes_pkg::rx_word_t rx_word;
	logic rx_valid;

	logic [31:0] rng; // xorshift state
	int cyc; // model: edges since reset release
	int strobe_cnt; // model: tx strobes sampled
	logic exp_strobe;
	logic exp_locked;
	logic exp_valid;
	logic exp_d1;
	logic exp_d2;
	serdes_pkg::rx_word_t exp_rx_word;
	logic q1[$]; // bits still to leave on d1, next one first
	logic q2[$];
	logic din_hist[$]; // every data_in bit sampled, reset edges too
	logic d1_hist[$]; // expected d1 after each edge, index = edge - 1
	int err_count;
	int check_count;
	int tests_run;
	int test_err_start;
	int test_chk_start;

	serdes_io UUT (
		.clock   (clock),
		.rst_n   (rst_n),
		.tx_words(tx_words),
		.data_in (data_in),
		.tx_lines(tx_lines),
		.tx_strobe(tx_strobe),
		.locked  (locked),
		.rx_word (rx_word),
		.rx_valid(rx_valid)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("Error: %s is 0x%h, expected 0x%h after clock %0d", name, got, exp, cyc);
		err_count++;
	endtask

	task automatic plain_error(input string msg);
		$display("%s (after clock %0d)", msg, cyc);
		err_count++;
	endtask

	// advance the model by one rising edge, using the inputs the DUT just sampled
	task automatic model_edge();
		logic smp_tx;
		logic smp_rx;
		int n;
		din_hist.push_back(data_in); // rx sampling runs through reset as well
		if (!rst_n) begin
			cyc = 0;
			strobe_cnt = 0;
			exp_locked = 1'b0;
			exp_strobe = 1'b0;
			exp_valid = 1'b0;
			exp_d1 = 1'b1; // lines idle high
			exp_d2 = 1'b1;
			q1.delete();
			q2.delete();
			d1_hist.delete();
		end else begin
			smp_tx = ((cyc % TX_W) == TX_W - 1); // strobe level over the clock just ended
			smp_rx = ((cyc % RX_W) == RX_W - 1);
			cyc++;
			exp_d1 = (q1.size() != 0) ? q1.pop_front() : 1'b1; // nothing queued, line high
			exp_d2 = (q2.size() != 0) ? q2.pop_front() : 1'b1;
			if (smp_tx && exp_locked) begin // load uses lock from before this edge
				for (int i = TX_W - 1; i >= 0; i--) begin
					q1.push_back(tx_words.word1[i]); // msb first
					q2.push_back(tx_words.word2[i]);
				end
			end
			if (smp_tx) begin
				strobe_cnt++;
				if (strobe_cnt >= LOCK_N) exp_locked = 1'b1; // sticky
			end
			exp_strobe = ((cyc % TX_W) == TX_W - 1);
			exp_valid = smp_rx; // pulse in the clock after capture
			n = din_hist.size();
			if (smp_rx && n >= RX_W) begin
				for (int i = 0; i < RX_W; i++) begin
					exp_rx_word[RX_W - 1 - i] = din_hist[n - RX_W + i];
				end
			end
			d1_hist.push_back(exp_d1);
		end
	endtask

	task automatic drive_inputs(input bit loop_mode, input logic rst_level);
		rst_n = rst_level;
		rng = xorshift32(rng);
		tx_words.word1 = rng[TX_W - 1:0]; // new words every clock
		tx_words.word2 = rng[2 * TX_W - 1:TX_W];
		rng = xorshift32(rng);
		if (loop_mode) data_in = tx_lines.d1; // loopback from lane 1
		else data_in = rng[0];
	endtask

	task automatic compare_outputs();
		check_count++;
		if (tx_strobe !== exp_strobe) begin
			value_error("tx_strobe", 32'(tx_strobe), 32'(exp_strobe));
		end
		if (locked !== exp_locked) begin
			value_error("locked", 32'(locked), 32'(exp_locked));
		end
		if (tx_lines.d1 !== exp_d1) begin
			value_error("tx_lines.d1", 32'(tx_lines.d1), 32'(exp_d1));
		end
		if (tx_lines.d2 !== exp_d2) begin
			value_error("tx_lines.d2", 32'(tx_lines.d2), 32'(exp_d2));
		end
		if (rx_valid !== exp_valid) begin
			value_error("rx_valid", 32'(rx_valid), 32'(exp_valid));
		end
		if (exp_valid && rx_word !== exp_rx_word) begin
			value_error("rx_word", 32'(rx_word), 32'(exp_rx_word));
		end
	endtask

	// one clock: model on the edge, drive shortly after, compare at the falling edge
	task automatic run_cycle(input bit loop_mode, input logic rst_level);
		@(posedge clock);
		model_edge();
		#1;
		drive_inputs(loop_mode, rst_level);
		@(negedge clock);
		compare_outputs();
	endtask

	task automatic start_test();
		test_err_start = err_count;
		test_chk_start = check_count;
	endtask

	task automatic report_test(input string name);
		tests_run++;
		$display("test %0d %s: %0d checks, %0d errors", tests_run, name,
			check_count - test_chk_start, err_count - test_err_start);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		int last_strobe;
		int lock_seen;
		int last_valid;
		int rx_words;
		int locked_strobes;
		int loop_start;
		int loop_words;
		serdes_pkg::rx_word_t exp_loop;
		rst_n = 1'b0;
		tx_words = '0;
		data_in = 1'b0;
		rng = SEED;
		cyc = 0;
		strobe_cnt = 0;
		exp_strobe = 1'b0;
		exp_locked = 1'b0;
		exp_valid = 1'b0;
		exp_d1 = 1'b1;
		exp_d2 = 1'b1;
		exp_rx_word = '0;
		err_count = 0;
		check_count = 0;
		tests_run = 0;

		start_test(); // reset values, held 5 edges, then just after release
		for (int i = 0; i < RESET_CYCLES; i++) run_cycle(0, (i == RESET_CYCLES - 1));
		for (int i = 0; i < SETTLE_CYCLES; i++) run_cycle(0, 1'b1);
		report_test("reset_state");

		start_test(); // strobe period and lock rise
		last_strobe = -1;
		lock_seen = -1;
		for (int i = 0; i < LOCK_CYCLES; i++) begin
			run_cycle(0, 1'b1);
			if (tx_strobe === 1'b1) begin
				if (last_strobe < 0 && cyc != TX_W - 1) begin
					plain_error($sformatf("first tx_strobe came in clock %0d, not %0d",
						cyc + 1, TX_W));
				end
				if (last_strobe >= 0 && cyc - last_strobe != TX_W) begin
					plain_error($sformatf("tx_strobe came %0d clocks after the previous one",
						cyc - last_strobe));
				end
				last_strobe = cyc;
			end
			if (locked === 1'b1 && lock_seen < 0) lock_seen = cyc;
		end
		if (lock_seen != LOCK_N * TX_W) begin
			plain_error($sformatf("locked rose after edge %0d, expected edge %0d", lock_seen,
				LOCK_N * TX_W));
		end
		report_test("strobe_and_lock");

		start_test(); // long random word stream on both lanes
		locked_strobes = 0;
		for (int i = 0; i < SERIAL_CYCLES; i++) begin
			run_cycle(0, 1'b1);
			if (tx_strobe === 1'b1 && locked === 1'b1) locked_strobes++;
		end
		if (locked_strobes != SERIAL_CYCLES / TX_W) begin
			plain_error("locked tx strobes do not match the word periods in the serialization test");
		end
		report_test("serialize");

		start_test(); // random rx bits, word content and pulse spacing
		last_valid = -1;
		rx_words = 0;
		for (int i = 0; i < DESERIAL_CYCLES; i++) begin
			run_cycle(0, 1'b1);
			if (rx_valid === 1'b1) begin
				if (last_valid >= 0 && cyc - last_valid != RX_W) begin
					plain_error($sformatf("rx_valid came %0d clocks after the previous one",
						cyc - last_valid));
				end
				last_valid = cyc;
				rx_words++;
			end
		end
		if (rx_words == 0) plain_error("no rx word seen in the deserialization test");
		report_test("deserialize");

		start_test(); // d1 looped into data_in, compared with the sent bit stream
		loop_start = cyc + 1; // first edge whose d1 value is driven back
		loop_words = 0;
		for (int i = 0; i < LOOP_CYCLES; i++) begin
			run_cycle(1, 1'b1);
			if (rx_valid === 1'b1 && cyc - RX_W >= loop_start) begin
				for (int k = 0; k < RX_W; k++) begin
					exp_loop[RX_W - 1 - k] = d1_hist[cyc - RX_W - 1 + k];
				end
				if (rx_word !== exp_loop) begin
					value_error("rx_word (loopback)", 32'(rx_word), 32'(exp_loop));
				end
				loop_words++;
			end
		end
		if (loop_words == 0) plain_error("no rx word fully inside the loopback window");
		report_test("loopback");

		$display("summary: %0d tests, %0d checks, %0d errors", tests_run, check_count, err_count);
		if (err_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
src/serdes_pkg.sv
src/strobe_gen.sv
src/lock_monitor.sv
src/oserdes_lane.sv
src/iserdes_lane.sv
src/serdes_io.sv
test/serdes_io_tb.sv

/* run.sh */
#!/bin/sh
# build the serdes testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f flist.f \
	--top-module serdes_io_tb \
	--Mdir obj_dir \
	-o serdes_io_sim

out=$(./obj_dir/serdes_io_sim)
echo "$out"

# pass only if the testbench printed its pass line
if echo "$out" | grep -qF '*** TEST PASSED ***'; then
	exit 0
fi
exit 1
